// ==== design/icache.sv ====
`timescale 1ns/1ps

module icache (
	input  logic                  clk,
	input  logic                  rst,
	input  icache_pkg::cpu_req_t  cpu_req,
	output icache_pkg::cpu_resp_t cpu_resp,
	output logic                  stall,
	output logic                  ready,
	input  logic                  invalidate,
	input  icache_pkg::addr_t     inv_addr,
	output icache_pkg::mem_req_t  mem_req,
	input  icache_pkg::mem_resp_t mem_resp
);

	function automatic icache_pkg::tag_t get_tag(input icache_pkg::addr_t addr);
		return addr[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_BITS];
	endfunction

	function automatic icache_pkg::index_t get_index(input icache_pkg::addr_t addr);
		return addr[icache_pkg::LINE_OFFSET_BITS +: icache_pkg::INDEX_BITS];
	endfunction

	function automatic icache_pkg::offset_t get_offset(input icache_pkg::addr_t addr);
		return addr[icache_pkg::BYTE_OFFSET_BITS +: icache_pkg::WORD_OFFSET_BITS];
	endfunction

	// stage 2
	logic              s2_read;
	icache_pkg::addr_t s2_addr;

	icache_pkg::tag_entry_t [icache_pkg::WAYS-1:0] tag_rdata;
	icache_pkg::line_t      [icache_pkg::WAYS-1:0] data_rdata;
	icache_pkg::tag_entry_t                        tag_wdata;
	logic [icache_pkg::WAYS-1:0] tag_we;
	logic [icache_pkg::WAYS-1:0] data_we;
	logic [icache_pkg::WAYS-1:0] hit;
	logic [icache_pkg::WAYS-1:0] way_valid;
	icache_pkg::index_t ram_waddr;
	icache_pkg::index_t ram_raddr;

	logic              s2_miss;
	logic              fill_pending;
	logic              filled;
	logic              refill_start;
	logic              line_done;
	icache_pkg::line_t refill_line;
	icache_pkg::way_t  victim;
	icache_pkg::word_t hit_word;
	logic              lfsr_update;
	logic [7:0]        lfsr_val;

	logic               sweeping;
	icache_pkg::index_t sweep_cnt;
	logic               inv_q;
	icache_pkg::index_t inv_index;

	logic              resp_valid;
	icache_pkg::word_t resp_data;

	for (genvar i = 0; i < icache_pkg::WAYS; i++) begin : g_hit
		assign way_valid[i] = tag_rdata[i].valid;
		assign hit[i]       = tag_rdata[i].valid && (tag_rdata[i].tag == get_tag(s2_addr));
	end

	// the cycle after line_done still sees the old tags, so it is masked
	assign s2_miss = s2_read && !(|hit) && !filled;

	assign stall = sweeping || s2_miss;
	assign ready = !sweeping;

	// keep the stalled lookup's set on the read port
	assign ram_raddr = stall ? get_index(s2_addr) : get_index(cpu_req.addr);

	assign refill_start = s2_miss && !fill_pending;

	// lowest invalid way, else random
	always_comb begin
		victim = icache_pkg::way_t'(lfsr_val[0]);
		for (int i = icache_pkg::WAYS - 1; i >= 0; i--) begin
			if (!way_valid[i]) begin
				victim = icache_pkg::way_t'(i);
			end
		end
	end

	assign lfsr_update = line_done && (&way_valid);

	always_comb begin
		hit_word = '0;
		for (int i = 0; i < icache_pkg::WAYS; i++) begin
			hit_word |= {icache_pkg::WORD_WIDTH{hit[i]}}
				& data_rdata[i][get_offset(s2_addr) * icache_pkg::WORD_WIDTH
				+: icache_pkg::WORD_WIDTH];
		end
	end

	// write port arbitration: sweep, then invalidate, then refill
	always_comb begin
		tag_we          = '0;
		data_we         = '0;
		ram_waddr       = get_index(s2_addr);
		tag_wdata.valid = 1'b0;
		tag_wdata.tag   = get_tag(s2_addr);
		if (sweeping) begin
			tag_we    = '1;
			ram_waddr = sweep_cnt;
		end else if (inv_q) begin
			tag_we    = '1;
			ram_waddr = inv_index;
		end else if (line_done) begin
			tag_we[victim]  = 1'b1;
			data_we[victim] = 1'b1;
			tag_wdata.valid = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s2_read <= 1'b0;
		end else if (!stall) begin
			s2_read <= cpu_req.read;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			s2_addr <= cpu_req.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fill_pending <= 1'b0;
			filled       <= 1'b0;
		end else begin
			filled <= line_done;
			if (refill_start) begin
				fill_pending <= 1'b1;
			end else if (line_done) begin
				fill_pending <= 1'b0;
			end
		end
	end

	// response: hit word, or word forwarded from the refilled line
	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= (s2_read && (|hit) && !filled) || line_done;
		end
	end

	always_ff @(posedge clk) begin
		if (line_done) begin
			resp_data <= refill_line[get_offset(s2_addr) * icache_pkg::WORD_WIDTH
				+: icache_pkg::WORD_WIDTH];
		end else begin
			resp_data <= hit_word;
		end
	end

	assign cpu_resp.valid = resp_valid;
	assign cpu_resp.data  = resp_data;

	// clear every set after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			sweeping  <= 1'b1;
			sweep_cnt <= '0;
		end else if (sweeping) begin
			sweep_cnt <= sweep_cnt + 1'b1;
			if (sweep_cnt == icache_pkg::index_t'(icache_pkg::SETS - 1)) begin
				sweeping <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			inv_q <= 1'b0;
		end else begin
			inv_q <= invalidate;
		end
	end

	always_ff @(posedge clk) begin
		inv_index <= get_index(inv_addr);
	end

	for (genvar i = 0; i < icache_pkg::WAYS; i++) begin : g_way
		icache_ram #(
			.WIDTH ($bits(icache_pkg::tag_entry_t)),
			.DEPTH (icache_pkg::SETS)
		) tag_ram (
			.clk   (clk),
			.we    (tag_we[i]),
			.waddr (ram_waddr),
			.wdata (tag_wdata),
			.raddr (ram_raddr),
			.rdata (tag_rdata[i])
		);

		icache_ram #(
			.WIDTH ($bits(icache_pkg::line_t)),
			.DEPTH (icache_pkg::SETS)
		) data_ram (
			.clk   (clk),
			.we    (data_we[i]),
			.waddr (ram_waddr),
			.wdata (refill_line),
			.raddr (ram_raddr),
			.rdata (data_rdata[i])
		);
	end

	icache_refill refill (
		.clk       (clk),
		.rst       (rst),
		.start     (refill_start),
		.line_addr ({s2_addr[icache_pkg::ADDR_WIDTH-1:icache_pkg::LINE_OFFSET_BITS],
			{icache_pkg::LINE_OFFSET_BITS{1'b0}}}),
		.hold      (inv_q),
		.mem_req   (mem_req),
		.mem_resp  (mem_resp),
		.line_done (line_done),
		.line      (refill_line)
	);

	icache_lfsr lfsr (
		.clk    (clk),
		.rst    (rst),
		.update (lfsr_update),
		.val    (lfsr_val)
	);

endmodule

// ==== design/icache_lfsr.sv ====
`timescale 1ns/1ps

module icache_lfsr (
	input  logic       clk,
	input  logic       rst,
	input  logic       update,
	output logic [7:0] val
);

	// taps for x^8 + x^6 + x^5 + x^4 + 1, right-shifting galois form
	localparam logic [7:0] TAPS = 8'hb8;
	localparam logic [7:0] SEED = 8'h5a;

	logic [7:0] next_val;

	assign next_val = {1'b0, val[7:1]} ^ (val[0] ? TAPS : 8'h00);

	always_ff @(posedge clk) begin
		if (rst) begin
			val <= SEED;
		end else if (update) begin
			val <= next_val;
		end
	end

endmodule

// ==== design/icache_pkg.sv ====
package icache_pkg;

	// cache geometry
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_WIDTH = 32;
	localparam int LINE_WORDS = 4;
	localparam int WAYS       = 2;
	localparam int SETS       = 16;

	localparam int BYTE_OFFSET_BITS = $clog2(WORD_WIDTH / 8);
	localparam int WORD_OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int LINE_OFFSET_BITS = BYTE_OFFSET_BITS + WORD_OFFSET_BITS;
	localparam int INDEX_BITS       = $clog2(SETS);
	localparam int TAG_BITS         = ADDR_WIDTH - INDEX_BITS - LINE_OFFSET_BITS;
	localparam int LINE_WIDTH       = LINE_WORDS * WORD_WIDTH;

	// arlen encodes beats minus one
	localparam logic [7:0] BURST_LEN = 8'(LINE_WORDS - 1);

	typedef logic [ADDR_WIDTH-1:0]       addr_t;
	typedef logic [WORD_WIDTH-1:0]       word_t;
	typedef logic [TAG_BITS-1:0]         tag_t;
	typedef logic [INDEX_BITS-1:0]       index_t;
	typedef logic [WORD_OFFSET_BITS-1:0] offset_t;
	typedef logic [LINE_WIDTH-1:0]       line_t;
	typedef logic [$clog2(WAYS)-1:0]     way_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef struct packed {
		logic  read;
		addr_t addr;
	} cpu_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} cpu_resp_t;

	// read channels only
	typedef struct packed {
		logic       arvalid;
		addr_t      araddr;
		logic [7:0] arlen;
		logic       rready;
	} mem_req_t;

	typedef struct packed {
		logic  arready;
		logic  rvalid;
		word_t rdata;
		logic  rlast;
	} mem_resp_t;

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		RECV,
		DONE
	} refill_state_t;

endpackage

// ==== design/icache_ram.sv ====
`timescale 1ns/1ps

module icache_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     we,
	input  icache_pkg::index_t       waddr,
	input  logic [WIDTH-1:0]         wdata,
	input  icache_pkg::index_t       raddr,
	output logic [WIDTH-1:0]         rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// read returns old contents on a same-edge write
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== design/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  icache_pkg::addr_t     line_addr,
	input  logic                  hold,
	output icache_pkg::mem_req_t  mem_req,
	input  icache_pkg::mem_resp_t mem_resp,
	output logic                  line_done,
	output icache_pkg::line_t     line
);

	icache_pkg::refill_state_t state;
	icache_pkg::refill_state_t state_next;

	icache_pkg::addr_t   addr_q;
	icache_pkg::offset_t beat_cnt;
	icache_pkg::line_t   line_buf;

	logic beat;

	// a beat moves only when the invalidation is not holding the engine
	assign beat = (state == icache_pkg::RECV) && mem_resp.rvalid && !hold;

	always_comb begin
		mem_req         = '0;
		mem_req.araddr  = addr_q;
		mem_req.arlen   = icache_pkg::BURST_LEN;
		mem_req.arvalid = (state == icache_pkg::ADDR);
		mem_req.rready  = (state == icache_pkg::RECV) && !hold;
	end

	// done waits out a hold too, since the tag write port is taken
	assign line_done = (state == icache_pkg::DONE) && !hold;
	assign line      = line_buf;

	always_comb begin
		state_next = state;
		unique case (state)
			icache_pkg::IDLE: begin
				if (start) begin
					state_next = icache_pkg::ADDR;
				end
			end
			icache_pkg::ADDR: begin
				if (mem_resp.arready) begin
					state_next = icache_pkg::RECV;
				end
			end
			icache_pkg::RECV: begin
				if (beat && mem_resp.rlast) begin
					state_next = icache_pkg::DONE;
				end
			end
			icache_pkg::DONE: begin
				if (!hold) begin
					state_next = icache_pkg::IDLE;
				end
			end
			default: begin
				state_next = icache_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icache_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	// beat position within the line
	always_ff @(posedge clk) begin
		if (rst) begin
			beat_cnt <= '0;
		end else if (state == icache_pkg::IDLE && start) begin
			beat_cnt <= '0;
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == icache_pkg::IDLE && start) begin
			addr_q <= line_addr;
		end
	end

	// incrementing burst, so beat n lands in word n
	always_ff @(posedge clk) begin
		if (beat) begin
			line_buf[beat_cnt * icache_pkg::WORD_WIDTH +: icache_pkg::WORD_WIDTH]
				<= mem_resp.rdata;
		end
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module icache_tb \
	-f sources.f \
	-o icache_sim

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
else
	echo "simulation reported failure, see sim.log"
	exit 1
fi

// ==== sources.f ====
design/icache_pkg.sv
design/icache_lfsr.sv
design/icache_ram.sv
design/icache_refill.sv
design/icache.sv
test/icache_assertions.sv
test/icache_tb.sv

// ==== test/icache_assertions.sv ====
`timescale 1ns/1ps

module icache_assertions (
	input logic                  clk,
	input logic                  rst,
	input icache_pkg::mem_req_t  mem_req,
	input icache_pkg::mem_resp_t mem_resp,
	input icache_pkg::cpu_resp_t cpu_resp,
	input logic                  ready,
	input logic                  invalidate
);

	// address phase holds until accepted
	ar_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req.arvalid && !mem_resp.arready |=> mem_req.arvalid && $stable(mem_req.araddr))
		else $error("arvalid or araddr changed before arready");

	ar_aligned: assert property (@(posedge clk) disable iff (rst)
		mem_req.arvalid |-> mem_req.araddr[icache_pkg::LINE_OFFSET_BITS-1:0] == '0)
		else $error("araddr is not line aligned");

	// no beat moves while the registered invalidation owns the tag port
	inv_blocks_beat: assert property (@(posedge clk) disable iff (rst)
		invalidate |=> !mem_req.rready)
		else $error("rready high while an invalidation is registered");

	resp_after_sweep: assert property (@(posedge clk) disable iff (rst)
		$rose(cpu_resp.valid) |-> ready)
		else $error("response raised during the reset sweep");

endmodule

bind icache icache_assertions assertions (
	.clk        (clk),
	.rst        (rst),
	.mem_req    (mem_req),
	.mem_resp   (mem_resp),
	.cpu_resp   (cpu_resp),
	.ready      (ready),
	.invalidate (invalidate)
);

// ==== test/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

	localparam icache_pkg::word_t MEM_KEY = 32'hc3a5_1e69;

	logic                  clk = 1'b0;
	logic                  rst;
	icache_pkg::cpu_req_t  cpu_req;
	icache_pkg::cpu_resp_t cpu_resp;
	logic                  stall;
	logic                  ready;
	logic                  invalidate;
	icache_pkg::addr_t     inv_addr;
	icache_pkg::mem_req_t  mem_req;
	icache_pkg::mem_resp_t mem_resp = '0;

	int seed = 40006;
	icache_pkg::word_t expected[$];
	bit resident[8];
	int bursts = 0;
	int fetches = 0;
	int proven_hits = 0;
	int run_len = 0;
	int max_run = 0;
	int error_count = 0;

	// memory responder state
	int r_state = 0;
	int ar_wait = 0;
	int gap = 0;
	int beat_idx = 0;
	icache_pkg::addr_t beat_addr;
	bit beat_taken = 1'b0;

	always #20 clk = ~clk;

	icache uut (
		.clk        (clk),
		.rst        (rst),
		.cpu_req    (cpu_req),
		.cpu_resp   (cpu_resp),
		.stall      (stall),
		.ready      (ready),
		.invalidate (invalidate),
		.inv_addr   (inv_addr),
		.mem_req    (mem_req),
		.mem_resp   (mem_resp)
	);

	function automatic int urand(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
		icache_pkg::word_t key;
		key = MEM_KEY;
		repeat (int'(a[3:2])) key = {key[23:0], key[31:24]};
		return {a[31:2], 2'b00} ^ key;
	endfunction

	// 8 lines over 3 tags where lines 0 to 2 share set 3
	function automatic icache_pkg::index_t pool_index(input int line);
		case (line)
			0, 1, 2: return 4'd3;
			3, 4:    return 4'd5;
			5, 6:    return 4'd9;
			default: return 4'd12;
		endcase
	endfunction

	function automatic icache_pkg::tag_t pool_tag(input int line);
		case (line)
			0, 3, 5: return 24'h000010;
			1, 4, 7: return 24'h0abc01;
			default: return 24'h123456;
		endcase
	endfunction

	function automatic icache_pkg::addr_t pool_addr(input int line, input int word);
		return {pool_tag(line), pool_index(line), icache_pkg::offset_t'(word), 2'b00};
	endfunction

	function automatic void clear_set(input icache_pkg::index_t idx);
		for (int i = 0; i < 8; i++) begin
			if (pool_index(i) == idx) resident[i] = 1'b0;
		end
	endfunction

	task automatic abort_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			error_count++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	// drive one fetch and hold it until accepted
	task automatic issue(input int line, input int word);
		int waited;
		icache_pkg::addr_t a;
		a = pool_addr(line, word);
		cpu_req.read = 1'b1;
		cpu_req.addr = a;
		waited = 0;
		while (stall) begin
			@(negedge clk);
			waited++;
			if (waited > 300) abort_run("a fetch was never accepted by the cache");
		end
		expected.push_back(mem_word(a));
		fetches++;
		if (resident[line]) begin
			proven_hits++;
		end else begin
			clear_set(pool_index(line));
		end
		resident[line] = 1'b1;
		@(negedge clk);
	endtask

	task automatic drain();
		int waited;
		cpu_req.read = 1'b0;
		waited = 0;
		while (expected.size() != 0 || stall) begin
			@(negedge clk);
			waited++;
			if (waited > 500) abort_run("responses did not arrive in time");
		end
	endtask

	task automatic invalidate_line(input int line);
		invalidate = 1'b1;
		inv_addr   = pool_addr(line, 0);
		@(negedge clk);
		invalidate = 1'b0;
		clear_set(pool_index(line));
	endtask

	task automatic wait_for_refill();
		int waited;
		waited = 0;
		while (!mem_req.rready) begin
			@(negedge clk);
			waited++;
			if (waited > 100) abort_run("the refill never reached its data phase");
		end
	endtask

	// memory side makes one decision per falling edge
	always @(negedge clk) begin
		if (rst) begin
			r_state    = 0;
			mem_resp   = '0;
			beat_taken = 1'b0;
		end else begin
			mem_resp.arready = 1'b0;
			if (beat_taken) begin
				beat_idx++;
				mem_resp.rvalid = 1'b0;
				mem_resp.rlast  = 1'b0;
				beat_taken      = 1'b0;
				gap             = urand(3);
				if (beat_idx == 4) r_state = 0;
			end
			if (r_state == 0 && mem_req.arvalid) begin
				ar_wait = urand(4);
				r_state = 1;
			end
			if (r_state == 1) begin
				if (ar_wait == 0) begin
					check("burst length", 32'd3, 32'(mem_req.arlen));
					mem_resp.arready = 1'b1;
					beat_addr        = mem_req.araddr;
					beat_idx         = 0;
					gap              = urand(3);
					bursts++;
					r_state = 2;
				end else begin
					ar_wait--;
				end
			end else if (r_state == 2 && !mem_resp.rvalid) begin
				if (gap == 0) begin
					mem_resp.rvalid = 1'b1;
					mem_resp.rdata  = mem_word(beat_addr + icache_pkg::addr_t'(beat_idx * 4));
					mem_resp.rlast  = (beat_idx == 3);
				end else begin
					gap--;
				end
			end
			beat_taken = (r_state == 2) && mem_resp.rvalid && mem_req.rready;
		end
	end

	// response checker against the expected queue
	always @(negedge clk) begin
		if (!rst && cpu_resp.valid) begin
			run_len++;
			if (run_len > max_run) max_run = run_len;
			if (expected.size() == 0) begin
				abort_run("the cache returned a word that no fetch asked for");
			end else begin
				check("fetch data", expected.pop_front(), cpu_resp.data);
			end
		end else begin
			run_len = 0;
		end
	end

	initial begin
		int b0;
		int f0;
		int h0;
		int waited;
		rst        = 1'b1;
		cpu_req    = '0;
		invalidate = 1'b0;
		inv_addr   = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		waited = 0;
		while (!ready) begin
			@(negedge clk);
			waited++;
			if (waited > 100) abort_run("ready never rose after reset");
		end

		// cold cache so every line misses once
		b0 = bursts;
		for (int l = 0; l < 8; l++) issue(l, l % 4);
		drain();
		check("cold misses", 32'd8, 32'(bursts - b0));

		// line 7 owns set 12 alone
		b0 = bursts;
		max_run = 0;
		for (int w = 0; w < 4; w++) issue(7, w);
		drain();
		check("hits issue no burst", 32'(b0), 32'(bursts));
		check("back-to-back hits", 32'd1, 32'(max_run >= 4));

		invalidate_line(7);
		repeat (3) @(negedge clk);
		b0 = bursts;
		issue(7, 2);
		drain();
		check("refetch after invalidate", 32'd1, 32'(bursts - b0));

		// invalidate the set while its refill is receiving beats
		invalidate_line(3);
		repeat (3) @(negedge clk);
		b0 = bursts;
		issue(3, 1);
		wait_for_refill();
		invalidate_line(3);
		drain();
		clear_set(pool_index(3));
		check("invalidate during refill", 32'd1, 32'(bursts - b0));
		issue(3, 0);
		drain();

		// three tags on one set
		b0 = bursts;
		f0 = fetches;
		h0 = proven_hits;
		for (int i = 0; i < 60; i++) issue(urand(3), urand(4));
		drain();
		check("conflict bursts bound", 32'd1,
			32'((bursts - b0) <= (fetches - f0) - (proven_hits - h0)));
		check("conflict caused refills", 32'd1, 32'((bursts - b0) > 0));

		b0 = bursts;
		f0 = fetches;
		h0 = proven_hits;
		for (int i = 0; i < 300; i++) begin
			if (urand(4) == 0) begin
				cpu_req.read = 1'b0;
				@(negedge clk);
			end
			issue(urand(8), urand(4));
		end
		drain();
		check("random bursts bound", 32'd1,
			32'((bursts - b0) <= (fetches - f0) - (proven_hits - h0)));

		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
